//--- Bender.yml
package:
  name: rfArray

sources:
  - files:
      - verilog/rfCfgPkg.sv
      - verilog/rfDftPkg.sv
      - verilog/rfWriteStage.sv
      - verilog/rfBank.sv
      - verilog/rfReadSelect.sv
      - verilog/rfObsCompactor.sv
      - verilog/rfArrayTop.sv
  - target: test
    files:
      - bench/rfClockGen.sv
      - bench/rfArrayTb.sv

//--- bench/rfArrayTb.sv
// self-checking testbench for the register file top, run with the project file list
module rfArrayTb;

  localparam int clockPeriod = 20;
  // cycle budget per test, the watchdog adds a margin on top
  localparam int runCycles = 11 + 36 + 70 + 304 + 14;
  localparam int watchdogCycles = runCycles + 100;

  logic clock;
  logic arstN;
  logic writeEn;
  rfCfgPkg::addrWord writeAddr;
  rfCfgPkg::dataWord writeData;
  logic readEn;
  rfCfgPkg::addrWord readAddr;
  logic scanWriteThru;
  rfCfgPkg::dataWord readData;
  rfDftPkg::obsWord obsOut;

  // model state, updated at each rising edge from the pins the DUT samples there
  rfCfgPkg::dataWord shadow [rfCfgPkg::entryCount];
  logic pendWe;
  rfCfgPkg::addrWord pendAddr;
  rfCfgPkg::dataWord pendData;
  rfCfgPkg::dataWord stagedPrev;
  rfCfgPkg::dataWord expRead;
  rfDftPkg::obsWord expObs;

  integer seed;
  int passCount;
  int failCount;
  logic checkOn;

  rfClockGen uClockGen (
    .clock (clock),
    .arstN (arstN)
  );

  rfArrayTop u_rfArrayTop (
    .clock         (clock),
    .arstN         (arstN),
    .writeEn       (writeEn),
    .writeAddr     (writeAddr),
    .writeData     (writeData),
    .readEn        (readEn),
    .readAddr      (readAddr),
    .scanWriteThru (scanWriteThru),
    .readData      (readData),
    .obsOut        (obsOut)
  );

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------

  // pins are concatenated in field order and folded three at a time,
  // the last group absorbs any leftover pins
  function automatic rfDftPkg::obsWord refObs(input rfCfgPkg::addrWord ra,
                                              input rfCfgPkg::addrWord wa,
                                              input logic re, input logic we);
    logic [rfDftPkg::obsPinCount-1:0] flat;
    rfDftPkg::obsWord result;
    int grp;
    flat = {ra, wa, re, we};
    result = '0;
    for (int b = 0; b < rfDftPkg::obsPinCount; b++)
    begin
      grp = b / rfDftPkg::obsXorSize;
      if (grp > rfDftPkg::obsFlopCount - 1)
      begin
        grp = rfDftPkg::obsFlopCount - 1;
      end
      result[grp] = result[grp] ^ flat[b];
    end
    return result;
  endfunction

  // a read sees storage as it was before this edge, so the write from the
  // previous edge is applied only after the read has been predicted
  always @(posedge clock)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < rfCfgPkg::entryCount; i++)
      begin
        shadow[i] = '0;
      end
      pendWe = 1'b0;
      pendAddr = '0;
      pendData = '0;
      stagedPrev = '0;
      expRead = '0;
      expObs = '0;
    end
    else
    begin
      if (readEn)
      begin
        expRead = scanWriteThru ? stagedPrev : shadow[readAddr];
      end
      if (pendWe)
      begin
        shadow[pendAddr] = pendData;
      end
      // write data is staged on every edge, only the array write is gated
      pendWe = writeEn && !scanWriteThru;
      pendAddr = writeAddr;
      pendData = writeData;
      stagedPrev = writeData;
      expObs = refObs(readAddr, writeAddr, readEn, writeEn);
    end
  end

  // ----------------------------------------------------------------------
  // checking
  // ----------------------------------------------------------------------

  task automatic checkData(input rfCfgPkg::dataWord actual, input rfCfgPkg::dataWord expected,
                           input string what);
    if (actual === expected)
    begin
      passCount++;
    end
    else
    begin
      failCount++;
      $display("FAILED at time %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic checkObs(input rfDftPkg::obsWord actual, input rfDftPkg::obsWord expected,
                          input string what);
    if (actual === expected)
    begin
      passCount++;
    end
    else
    begin
      failCount++;
      $display("FAILED at time %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // outputs settle after the rising edge, the falling edge is a quiet point
  always @(negedge clock)
  begin
    if (checkOn)
    begin
      checkData(readData, expRead, "readData");
      checkObs(obsOut, expObs, "obsOut");
    end
  end

  task automatic reportTest(input string name, input int errorsBefore);
    if (failCount == errorsBefore)
    begin
      $display("test %s done: no errors", name);
    end
    else
    begin
      $display("test %s done: %0d errors", name, failCount - errorsBefore);
    end
  endtask

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------

  task automatic applyCycle(input logic we, input rfCfgPkg::addrWord wa,
                            input rfCfgPkg::dataWord wd, input logic re,
                            input rfCfgPkg::addrWord ra, input logic swt);
    @(posedge clock);
    writeEn <= we;
    writeAddr <= wa;
    writeData <= wd;
    readEn <= re;
    readAddr <= ra;
    scanWriteThru <= swt;
  endtask

  // addresses, data and the SWT level hold, only the strobes drop
  task automatic idleCycle();
    @(posedge clock);
    writeEn <= 1'b0;
    readEn <= 1'b0;
  endtask

  function automatic rfCfgPkg::dataWord randWord();
    logic [63:0] wide;
    wide = {$random(seed), $random(seed)};
    return wide[rfCfgPkg::dataWidth-1:0];
  endfunction

  // every address bit reaches the pattern, so aliased entries differ
  function automatic rfCfgPkg::dataWord fillPattern(input int addr);
    logic [31:0] mix;
    mix = addr * 32'h9e3779b1;
    return {6'(addr), 8'ha5 ^ 8'(addr), mix ^ 32'(addr)};
  endfunction

  initial
  begin
    int errorsBefore;
    logic [31:0] rnd;
    rfCfgPkg::addrWord lastAddr;
    rfCfgPkg::addrWord swtAddr;
    rfCfgPkg::dataWord oldWord;
    rfCfgPkg::dataWord swtWord;
    writeEn = 1'b0;
    writeAddr = '0;
    writeData = '0;
    readEn = 1'b0;
    readAddr = '0;
    scanWriteThru = 1'b0;
    seed = 32'had823686;
    passCount = 0;
    failCount = 0;
    checkOn = 1'b0;
    lastAddr = '0;

    // reset values, then a read of every entry
    wait (arstN === 1'b1);
    errorsBefore = failCount;
    checkData(readData, '0, "readData after reset");
    checkObs(obsOut, '0, "obsOut after reset");
    checkOn = 1'b1;
    for (int a = 0; a < rfCfgPkg::entryCount; a++)
    begin
      applyCycle(1'b0, '0, '0, 1'b1, rfCfgPkg::addrWord'(a), 1'b0);
    end
    idleCycle();
    idleCycle();
    reportTest("reset", errorsBefore);

    // all entries written first, then read back in order
    errorsBefore = failCount;
    for (int a = 0; a < rfCfgPkg::entryCount; a++)
    begin
      applyCycle(1'b1, rfCfgPkg::addrWord'(a), fillPattern(a), 1'b0, '0, 1'b0);
    end
    idleCycle();
    idleCycle();
    for (int a = 0; a < rfCfgPkg::entryCount; a++)
    begin
      applyCycle(1'b0, '0, '0, 1'b1, rfCfgPkg::addrWord'(a), 1'b0);
    end
    idleCycle();
    idleCycle();
    reportTest("directed fill", errorsBefore);

    // slots 1 and 2 read back the address written in slot 0
    errorsBefore = failCount;
    for (int i = 0; i < 300; i++)
    begin
      rnd = $random(seed);
      case (i % 4)
        0:
        begin
          lastAddr = rfCfgPkg::addrWord'(rnd[28:24]);
          applyCycle(1'b1, lastAddr, randWord(), rnd[0], rnd[12:8], 1'b0);
        end
        1, 2:
        begin
          applyCycle(rnd[1], rnd[20:16], randWord(), 1'b1, lastAddr, 1'b0);
        end
        default:
        begin
          applyCycle(rnd[1], rnd[20:16], randWord(), rnd[2], rnd[12:8], 1'b0);
        end
      endcase
    end
    idleCycle();
    idleCycle();
    reportTest("random traffic", errorsBefore);

    // an SWT write must reach the read port but not the array
    errorsBefore = failCount;
    swtAddr = 5'd5;
    oldWord = 46'h1234_5678_9abc;
    swtWord = 46'h2bad_c0de_f00d;
    applyCycle(1'b1, swtAddr, oldWord, 1'b0, swtAddr, 1'b0);
    idleCycle();
    idleCycle();
    applyCycle(1'b1, swtAddr, swtWord, 1'b0, swtAddr, 1'b1);
    applyCycle(1'b0, swtAddr, swtWord, 1'b1, swtAddr, 1'b1);
    idleCycle();
    @(negedge clock);
    checkData(readData, swtWord, "readData in SWT mode");
    applyCycle(1'b0, swtAddr, '0, 1'b0, swtAddr, 1'b0);
    applyCycle(1'b0, swtAddr, '0, 1'b1, swtAddr, 1'b0);
    idleCycle();
    @(negedge clock);
    checkData(readData, oldWord, "readData after SWT");
    idleCycle();
    reportTest("scan write-through", errorsBefore);

    $display("checks: %0d passed, %0d failed", passCount, failCount);
    if (failCount == 0)
    begin
      $display("TESTBENCH PASSED");
    end
    else
    begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial
  begin
    #(watchdogCycles * clockPeriod);
    $display("watchdog: the run did not finish within %0d cycles and was stopped",
             watchdogCycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- bench/rfClockGen.sv
// clock and reset source for the register file testbench, instantiated once by the bench top
module rfClockGen (
  output logic clock,
  output logic arstN
);

  // clock period in time units
  localparam int period = 20;
  // number of rising edges seen with reset held low
  localparam int resetCycles = 10;

  initial
  begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  // release lands between a falling and a rising edge so no edge races it
  initial
  begin
    arstN = 1'b0;
    #(resetCycles * period + period / 4);
    arstN = 1'b1;
  end

endmodule

//--- rfArray.f
verilog/rfCfgPkg.sv
verilog/rfDftPkg.sv
verilog/rfWriteStage.sv
verilog/rfBank.sv
verilog/rfReadSelect.sv
verilog/rfObsCompactor.sv
verilog/rfArrayTop.sv
bench/rfClockGen.sv
bench/rfArrayTb.sv

//--- verilog/rfArrayTop.sv
// top of the 32x46 1R1W register file with scan write-through and pin observation flops
module rfArrayTop (
  input  logic               clock,
  input  logic               arstN,
  input  logic               writeEn,
  input  rfCfgPkg::addrWord  writeAddr,
  input  rfCfgPkg::dataWord  writeData,
  input  logic               readEn,
  input  rfCfgPkg::addrWord  readAddr,
  input  logic               scanWriteThru,
  output rfCfgPkg::dataWord  readData,
  output rfDftPkg::obsWord   obsOut
);

  // staging outputs shared by all banks
  logic [rfCfgPkg::bankCount-1:0]      bankWriteEn;
  logic [rfCfgPkg::entryIdxWidth-1:0]  stagedIdx;
  rfCfgPkg::dataWord                   stagedData;

  // each bank's word for the entry index of readAddr
  rfCfgPkg::dataWord bankWords [rfCfgPkg::bankCount];

  // pins seen by the observation flops
  rfDftPkg::obsPins obsPinWord;

  // ----------------------------------------------------------------------
  // write path
  // ----------------------------------------------------------------------

  rfWriteStage uWriteStage (
    .clock         (clock),
    .arstN         (arstN),
    .writeEn       (writeEn),
    .writeAddr     (writeAddr),
    .writeData     (writeData),
    .scanWriteThru (scanWriteThru),
    .bankWriteEn   (bankWriteEn),
    .stagedIdx     (stagedIdx),
    .stagedData    (stagedData)
  );

  // all banks see the same index and data, only one gets a write enable
  for (genvar b = 0; b < rfCfgPkg::bankCount; b++)
  begin : bankGen
    rfBank uBank (
      .clock     (clock),
      .arstN     (arstN),
      .writeEn   (bankWriteEn[b]),
      .writeIdx  (stagedIdx),
      .writeData (stagedData),
      .readIdx   (readAddr[rfCfgPkg::entryIdxWidth-1:0]),
      .readWord  (bankWords[b])
    );
  end

  // ----------------------------------------------------------------------
  // read path
  // ----------------------------------------------------------------------

  rfReadSelect uReadSelect (
    .clock         (clock),
    .arstN         (arstN),
    .readEn        (readEn),
    .readAddr      (readAddr),
    .bankWords     (bankWords),
    .stagedData    (stagedData),
    .scanWriteThru (scanWriteThru),
    .readData      (readData)
  );

  // observed pins are packed by name, the compactor reads the flat view
  always_comb
  begin
    obsPinWord.named.readAddr  = readAddr;
    obsPinWord.named.writeAddr = writeAddr;
    obsPinWord.named.readEn    = readEn;
    obsPinWord.named.writeEn   = writeEn;
  end

  rfObsCompactor uObsCompactor (
    .clock  (clock),
    .arstN  (arstN),
    .pins   (obsPinWord),
    .obsOut (obsOut)
  );

endmodule

//--- verilog/rfBank.sv
// one storage bank of the register file, written from the staging stage and read combinationally
module rfBank (
  input  logic                                clock,
  input  logic                                arstN,
  input  logic                                writeEn,
  input  logic [rfCfgPkg::entryIdxWidth-1:0]  writeIdx,
  input  rfCfgPkg::dataWord                   writeData,
  input  logic [rfCfgPkg::entryIdxWidth-1:0]  readIdx,
  output rfCfgPkg::dataWord                   readWord
);

  // storage for this bank's slice of the address space
  rfCfgPkg::dataWord entries [rfCfgPkg::bankDepth];

  // ----------------------------------------------------------------------
  // write port
  // ----------------------------------------------------------------------

  // writes arrive one edge after the request, already decoded to this bank
  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < rfCfgPkg::bankDepth; i++)
      begin
        entries[i] <= '0;
      end
    end
    else if (writeEn)
    begin
      entries[writeIdx] <= writeData;
    end
  end

  // ----------------------------------------------------------------------
  // read port
  // ----------------------------------------------------------------------

  // the read selector registers this word, so no flop is needed here
  assign readWord = entries[readIdx];

  // the staged index must be settled whenever the staging stage enables this bank
  writeIdxKnown: assert property (@(posedge clock) disable iff (!arstN)
    writeEn |-> !$isunknown(writeIdx))
    else $error("bank write with unknown entry index");

endmodule

//--- verilog/rfCfgPkg.sv
// array geometry of the 32x46 register file, referenced by scoped names from the RTL
package rfCfgPkg;

  // ----------------------------------------------------------------------
  // array size
  // ----------------------------------------------------------------------

  // total number of storage entries in the macro
  localparam int entryCount = 32;
  // width of one stored word
  localparam int dataWidth = 46;

  // the array is split into equal banks so a read is a small mux per bank
  // followed by one bank select
  localparam int bankCount = 4;
  localparam int bankDepth = entryCount / bankCount;

  // ----------------------------------------------------------------------
  // address split
  // ----------------------------------------------------------------------

  // full address, upper bits pick the bank and lower bits the entry inside it
  localparam int addrWidth = $clog2(entryCount);
  localparam int bankSelWidth = $clog2(bankCount);
  localparam int entryIdxWidth = $clog2(bankDepth);

  // one stored word as it travels between the blocks
  typedef logic [dataWidth-1:0] dataWord;

  // a full array address
  typedef logic [addrWidth-1:0] addrWord;

endpackage

//--- verilog/rfDftPkg.sv
// test structure definitions for the register file, used by the observation compactor and top
package rfDftPkg;

  // ----------------------------------------------------------------------
  // observation pin layout
  // ----------------------------------------------------------------------

  // the observed pins are both addresses plus the two enables
  localparam int obsPinCount = 2 * rfCfgPkg::addrWidth + 2;

  // number of pins folded into one XOR gate ahead of each flop
  localparam int obsXorSize = 3;

  // one flop per XOR group, a partial last group still needs its own flop
  localparam int obsFlopCount = (obsPinCount + obsXorSize - 1) / obsXorSize;

  // ----------------------------------------------------------------------
  // observed pin word
  // ----------------------------------------------------------------------

  // the top writes the pins by name while the compactor slices the same
  // word by bit position, so both views share one union
  // field order runs from the most significant bit down
  typedef union packed {
    struct packed {
      rfCfgPkg::addrWord readAddr;
      rfCfgPkg::addrWord writeAddr;
      logic              readEn;
      logic              writeEn;
    } named;
    logic [obsPinCount-1:0] flat;
  } obsPins;

  // captured XOR results, one bit per observation flop
  typedef logic [obsFlopCount-1:0] obsWord;

endpackage

//--- verilog/rfObsCompactor.sv
// observation flops for the register file, XOR-folds address and control pins into a few flops
module rfObsCompactor (
  input  logic              clock,
  input  logic              arstN,
  input  rfDftPkg::obsPins  pins,
  output rfDftPkg::obsWord  obsOut
);

  // combinational XOR of each pin group
  rfDftPkg::obsWord groupXor;

  // ----------------------------------------------------------------------
  // XOR groups
  // ----------------------------------------------------------------------

  // group i covers flat bits 3i up to 3i+2, the last group takes
  // whatever pins are left over
  for (genvar g = 0; g < rfDftPkg::obsFlopCount; g++)
  begin : groupGen
    if (g < rfDftPkg::obsFlopCount - 1)
    begin : fullGroup
      assign groupXor[g] =
        ^pins.flat[g*rfDftPkg::obsXorSize +: rfDftPkg::obsXorSize];
    end
    else
    begin : lastGroup
      assign groupXor[g] =
        ^pins.flat[rfDftPkg::obsPinCount-1 : g*rfDftPkg::obsXorSize];
    end
  end

  // ----------------------------------------------------------------------
  // observation flops
  // ----------------------------------------------------------------------

  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      obsOut <= '0;
    end
    else
    begin
      obsOut <= groupXor;
    end
  end

  // an X on any observed pin of the top shows up here one cycle later
  obsOutKnown: assert property (@(posedge clock) disable iff (!arstN) !$isunknown(obsOut))
    else $error("observation flops captured an unknown value");

endmodule

//--- verilog/rfReadSelect.sv
// read side of the register file, picks the addressed bank or the staged SWT word and registers it
module rfReadSelect (
  input  logic               clock,
  input  logic               arstN,
  input  logic               readEn,
  input  rfCfgPkg::addrWord  readAddr,
  input  rfCfgPkg::dataWord  bankWords [rfCfgPkg::bankCount],
  input  rfCfgPkg::dataWord  stagedData,
  input  logic               scanWriteThru,
  output rfCfgPkg::dataWord  readData
);

  // bank number from the upper read address bits
  logic [rfCfgPkg::bankSelWidth-1:0] readBank;
  // word that will be captured on a read edge
  rfCfgPkg::dataWord nextData;

  assign readBank = readAddr[rfCfgPkg::addrWidth-1 -: rfCfgPkg::bankSelWidth];

  // ----------------------------------------------------------------------
  // source select
  // ----------------------------------------------------------------------

  // in scan write-through the array is bypassed and the read returns
  // whatever the staging stage holds, otherwise the bank mux output is used
  always_comb
  begin
    if (scanWriteThru)
    begin
      nextData = stagedData;
    end
    else
    begin
      nextData = bankWords[readBank];
    end
  end

  // ----------------------------------------------------------------------
  // output register
  // ----------------------------------------------------------------------

  // readData only moves on a read strobe and holds between reads
  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      readData <= '0;
    end
    else if (readEn)
    begin
      readData <= nextData;
    end
  end

  // storage and staging both reset to zero, so an X here means a bad
  // address or a path that escaped reset
  readDataKnown: assert property (@(posedge clock) disable iff (!arstN)
    !$isunknown(readData))
    else $error("read data is unknown");

endmodule

//--- verilog/rfWriteStage.sv
// write staging for the register file, registers each write and decodes its target bank
module rfWriteStage (
  input  logic                                clock,
  input  logic                                arstN,
  input  logic                                writeEn,
  input  rfCfgPkg::addrWord                   writeAddr,
  input  rfCfgPkg::dataWord                   writeData,
  input  logic                                scanWriteThru,
  output logic [rfCfgPkg::bankCount-1:0]      bankWriteEn,
  output logic [rfCfgPkg::entryIdxWidth-1:0]  stagedIdx,
  output rfCfgPkg::dataWord                   stagedData
);

  // bank number taken from the upper address bits
  logic [rfCfgPkg::bankSelWidth-1:0] writeBank;
  // one-hot form of writeBank before gating
  logic [rfCfgPkg::bankCount-1:0]    bankDecode;

  assign writeBank = writeAddr[rfCfgPkg::addrWidth-1 -: rfCfgPkg::bankSelWidth];

  always_comb
  begin
    bankDecode = '0;
    bankDecode[writeBank] = 1'b1;
  end

  // ----------------------------------------------------------------------
  // staging registers
  // ----------------------------------------------------------------------

  // the data is captured on every edge so an SWT read sees the latest
  // write value, the banks only act on it through bankWriteEn
  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      bankWriteEn <= '0;
      stagedIdx   <= '0;
      stagedData  <= '0;
    end
    else
    begin
      stagedData <= writeData;
      if (writeEn)
      begin
        stagedIdx <= writeAddr[rfCfgPkg::entryIdxWidth-1:0];
        // scan write-through keeps the array contents untouched
        bankWriteEn <= scanWriteThru ? '0 : bankDecode;
      end
      else
      begin
        bankWriteEn <= '0;
      end
    end
  end

  // an accepted write outside scan write-through lands in exactly one bank
  bankEnOneHot: assert property (@(posedge clock) disable iff (!arstN)
    $past(writeEn && !scanWriteThru) |-> $onehot(bankWriteEn))
    else $error("accepted write did not enable exactly one bank");

endmodule
